/* files.f */
verilog/ddr_model_pkg.sv
verilog/ddr_cmd_decode.sv
verilog/ddr_burst_exec.sv
verilog/ddr_mem_array.sv
verilog/ddr_burst_model.sv
tb/tb_ddr_burst_model.sv

/* Bender.yml */
package:
  name: ddr_burst_model

sources:
  # Package first, then the RTL in dependency order
  - verilog/ddr_model_pkg.sv
  - verilog/ddr_cmd_decode.sv
  - verilog/ddr_burst_exec.sv
  - verilog/ddr_mem_array.sv
  - verilog/ddr_burst_model.sv

  - target: simulation
    files:
      - tb/tb_ddr_burst_model.sv

/* tb/tb_ddr_burst_model.sv */
// Testbench for the burst memory model. Expected values come from a shadow cycle model
`timescale 1ns/10ps

module tb_ddr_burst_model;

    import ddr_model_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int IDLE_LIMIT = INIT_CYCLES + READ_LATENCY + 16;

    // Cycle budget of the whole run, doubled for margin
    localparam int NUM_READS       = 7;
    localparam int NUM_WRITES      = 4;
    localparam int TOTAL_BEATS     = 50;
    localparam int START_CYCLES    = 3 + INIT_CYCLES + 8;
    localparam int BUDGET_CYCLES   = START_CYCLES + NUM_READS * (READ_LATENCY + 4)
                                     + NUM_WRITES * 4 + TOTAL_BEATS;
    localparam int WATCHDOG_CYCLES = 2 * BUDGET_CYCLES;

    logic   clk;
    logic   rst;
    logic   rd;
    logic   we;
    addr_t  addr;
    burst_t burstcnt;
    beat_t  din;
    be_t    be;
    logic   busy;
    beat_t  dout;
    logic   dout_ready;

    integer seed;
    string  test_name;
    int     mismatch_errors;
    int     other_errors;
    addr_t  alias_addr;

    // Reference model of the client-visible timing
    beat_t     shadow [MEM_DEPTH];
    int        busy_left;
    int        op_wait;
    int        beats_left;
    logic      ref_write;
    mem_addr_t cur_addr;
    logic      exp_busy;
    logic      exp_ready;
    beat_t     exp_dout;

    ddr_burst_model ddr_burst_model_inst (
        .clk        (clk),
        .rst        (rst),
        .rd         (rd),
        .we         (we),
        .addr       (addr),
        .burstcnt   (burstcnt),
        .din        (din),
        .be         (be),
        .busy       (busy),
        .dout       (dout),
        .dout_ready (dout_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Lane-wise merge of a new beat into an old one
    function automatic beat_t merge_lanes(input beat_t old_beat, input beat_t new_beat,
                                          input be_t lanes);
        beat_t merged;
        merged = old_beat;
        for (int lane = 0; lane < BE_W; lane++) begin
            if (lanes[lane]) begin
                merged[8*lane +: 8] = new_beat[8*lane +: 8];
            end
        end
        return merged;
    endfunction

    initial begin
        for (int i = 0; i < MEM_DEPTH; i++) begin
            shadow[i] = '0;
        end
    end

    assign exp_busy  = (busy_left != 0);
    assign exp_ready = !ref_write && (op_wait == 0) && (beats_left != 0);
    assign exp_dout  = shadow[cur_addr];

    // State below describes the cycle after each edge
    always @(posedge clk) begin
        if (rst) begin
            busy_left  <= INIT_CYCLES;
            op_wait    <= 0;
            beats_left <= 0;
            ref_write  <= 1'b0;
            cur_addr   <= '0;
        end else if ((rd || we) && !exp_busy) begin
            ref_write  <= we;
            cur_addr   <= addr[MEM_AW-1:0];
            beats_left <= int'(burstcnt);
            if (we) begin
                // Start cycle, then one beat per cycle
                op_wait   <= 1;
                busy_left <= int'(burstcnt) + 1;
            end else begin
                op_wait   <= READ_LATENCY;
                busy_left <= READ_LATENCY + int'(burstcnt) + 1;
            end
        end else begin
            if (busy_left != 0) begin
                busy_left <= busy_left - 1;
            end
            if (op_wait != 0) begin
                op_wait <= op_wait - 1;
            end else if (beats_left != 0) begin
                beats_left <= beats_left - 1;
                cur_addr   <= cur_addr + mem_addr_t'(1);
                if (ref_write) begin
                    shadow[cur_addr] <= merge_lanes(shadow[cur_addr], din, be);
                end
            end
        end
    end

    a_busy: assert property (@(posedge clk) disable iff (rst) busy == exp_busy)
        else begin
            mismatch_errors++;
            $display("Mismatch in %s: busy expected %0b, actual %0b",
                     test_name, $sampled(exp_busy), $sampled(busy));
        end

    a_ready: assert property (@(posedge clk) disable iff (rst) dout_ready == exp_ready)
        else begin
            mismatch_errors++;
            $display("Mismatch in %s: dout_ready expected %0b, actual %0b",
                     test_name, $sampled(exp_ready), $sampled(dout_ready));
        end

    a_dout: assert property (@(posedge clk) disable iff (rst) exp_ready |-> dout == exp_dout)
        else begin
            mismatch_errors++;
            $display("Mismatch in %s: dout expected %h, actual %h",
                     test_name, $sampled(exp_dout), $sampled(dout));
        end

    a_ready_in_busy: assert property (@(posedge clk) disable iff (rst) dout_ready |-> busy)
        else begin
            other_errors++;
            $display("Error in %s: dout_ready was high while busy was low", test_name);
        end

    // All tasks start and end 1 ns after a rising edge
    task automatic wait_until_idle();
        int waited;
        waited = 0;
        while (busy !== 1'b0 && waited < IDLE_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (busy !== 1'b0) begin
            other_errors++;
            $display("Error in %s: busy did not fall within %0d cycles", test_name, IDLE_LIMIT);
        end
    endtask

    task automatic write_burst(input addr_t start, input burst_t len, input logic full_be);
        wait_until_idle();
        we       = 1'b1;
        addr     = start;
        burstcnt = len;
        @(posedge clk);
        #1;
        we = 1'b0;
        @(posedge clk);
        #1;
        for (int i = 0; i < int'(len); i++) begin
            din = {$random(seed), $random(seed)};
            be  = full_be ? '1 : be_t'($random(seed));
            @(posedge clk);
            #1;
        end
    endtask

    task automatic read_burst(input addr_t start, input burst_t len);
        wait_until_idle();
        rd       = 1'b1;
        addr     = start;
        burstcnt = len;
        @(posedge clk);
        #1;
        rd = 1'b0;
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

    initial begin
        seed            = 33712;
        mismatch_errors = 0;
        other_errors    = 0;
        test_name       = "reset";
        rst             = 1'b1;
        rd              = 1'b0;
        we              = 1'b0;
        addr            = '0;
        burstcnt        = burst_t'(1);
        din             = '0;
        be              = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // Request inside the start-up window must be dropped
        test_name = "startup_busy";
        repeat (4) @(posedge clk);
        #1;
        rd       = 1'b1;
        addr     = addr_t'(40);
        burstcnt = burst_t'(2);
        repeat (2) @(posedge clk);
        #1;
        rd = 1'b0;

        test_name = "full_write_read";
        write_burst(addr_t'(16), burst_t'(8), 1'b1);
        read_burst(addr_t'(16), burst_t'(8));

        // Stray write in the middle of a read
        test_name = "read_timing";
        read_burst(addr_t'(16), burst_t'(4));
        repeat (3) @(posedge clk);
        #1;
        we       = 1'b1;
        addr     = addr_t'(16);
        burstcnt = burst_t'(1);
        din      = '1;
        be       = '1;
        repeat (2) @(posedge clk);
        #1;
        we = 1'b0;

        test_name = "byte_enables";
        write_burst(addr_t'(16), burst_t'(8), 1'b0);
        read_burst(addr_t'(16), burst_t'(8));

        test_name  = "addr_truncation";
        alias_addr = addr_t'($random(seed));
        alias_addr[ADDR_W-1]   = 1'b1;
        alias_addr[MEM_AW-1:0] = mem_addr_t'(300);
        write_burst(alias_addr, burst_t'(1), 1'b1);
        read_burst(addr_t'(300), burst_t'(1));

        test_name = "addr_wrap";
        write_burst(addr_t'(1022), burst_t'(4), 1'b1);
        read_burst(addr_t'(0), burst_t'(2));
        alias_addr[MEM_AW-1:0] = mem_addr_t'(1022);
        read_burst(alias_addr, burst_t'(2));

        test_name = "untouched_memory";
        read_burst(addr_t'(600), burst_t'(4));
        wait_until_idle();
        repeat (2) @(posedge clk);

        $display("Summary: %0d mismatches, %0d other errors", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* verilog/ddr_burst_model.sv */
// Top of the burst memory model. No handshake beyond busy and only the low MEM_AW address bits are decoded
`timescale 1ns/10ps

module ddr_burst_model (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rd,
    input  logic                   we,
    input  ddr_model_pkg::addr_t   addr,
    input  ddr_model_pkg::burst_t  burstcnt,
    input  ddr_model_pkg::beat_t   din,
    input  ddr_model_pkg::be_t     be,
    output logic                   busy,
    output ddr_model_pkg::beat_t   dout,
    output logic                   dout_ready
);

    import ddr_model_pkg::*;

    // Decode to execute
    logic      start;
    op_t       op;
    mem_addr_t start_addr;
    burst_t    length;

    // Execute back to decode and on to memory
    logic      idle;
    logic      wr_en;
    mem_addr_t beat_addr;

    ddr_cmd_decode ddr_cmd_decode_inst (
        .clk        (clk),
        .rst        (rst),
        .rd         (rd),
        .we         (we),
        .addr       (addr),
        .burstcnt   (burstcnt),
        .idle       (idle),
        .busy       (busy),
        .start      (start),
        .op         (op),
        .start_addr (start_addr),
        .length     (length)
    );

    ddr_burst_exec ddr_burst_exec_inst (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .op         (op),
        .start_addr (start_addr),
        .length     (length),
        .idle       (idle),
        .wr_en      (wr_en),
        .beat_addr  (beat_addr),
        .dout_ready (dout_ready)
    );

    // Write data and lane enables go straight to the array
    ddr_mem_array ddr_mem_array_inst (
        .clk       (clk),
        .wr_en     (wr_en),
        .beat_addr (beat_addr),
        .din       (din),
        .be        (be),
        .rd_data   (dout)
    );

endmodule

/* verilog/ddr_mem_array.sv */
// Beat memory of the model with byte lanes. Content is zero at time zero and has no reset
`timescale 1ns/10ps

module ddr_mem_array (
    input  logic                      clk,
    input  logic                      wr_en,
    input  ddr_model_pkg::mem_addr_t  beat_addr,
    input  ddr_model_pkg::beat_t      din,
    input  ddr_model_pkg::be_t        be,
    output ddr_model_pkg::beat_t      rd_data
);

    import ddr_model_pkg::*;

    beat_t mem [MEM_DEPTH];

    // Blank memory at start of simulation
    initial begin
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Only enabled lanes change
    always @(posedge clk) begin
        if (wr_en) begin
            for (int lane = 0; lane < BE_W; lane++) begin
                if (be[lane]) begin
                    mem[beat_addr][8*lane +: 8] <= din[8*lane +: 8];
                end
            end
        end
    end

    // Asynchronous read of the addressed beat
    assign rd_data = mem[beat_addr];

endmodule

/* verilog/ddr_burst_exec.sv */
// Burst sequencer. Addresses wrap at MEM_DEPTH and a read holds busy one cycle past its last beat
`timescale 1ns/10ps

module ddr_burst_exec (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  ddr_model_pkg::op_t        op,
    input  ddr_model_pkg::mem_addr_t  start_addr,
    input  ddr_model_pkg::burst_t     length,
    output logic                      idle,
    output logic                      wr_en,
    output ddr_model_pkg::mem_addr_t  beat_addr,
    output logic                      dout_ready
);

    import ddr_model_pkg::*;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        WRITE   = 2'd1,
        LATENCY = 2'd2,
        READ    = 2'd3
    } state_t;

    state_t    state;
    burst_t    beat_cnt;
    mem_addr_t addr_cnt;
    lat_t      lat_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            beat_cnt <= '0;
            addr_cnt <= '0;
            lat_cnt  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        beat_cnt <= length;
                        addr_cnt <= start_addr;
                        // One latency cycle is spent in the start cycle
                        // and one on the edge into READ
                        lat_cnt  <= lat_t'(READ_LATENCY - 2);
                        if (op == OP_WRITE) begin
                            state <= WRITE;
                        end else begin
                            state <= LATENCY;
                        end
                    end
                end

                WRITE: begin
                    // One beat per edge, last one returns to idle
                    addr_cnt <= addr_cnt + mem_addr_t'(1);
                    beat_cnt <= beat_cnt - burst_t'(1);
                    if (beat_cnt == burst_t'(1)) begin
                        state <= IDLE;
                    end
                end

                LATENCY: begin
                    lat_cnt <= lat_cnt - lat_t'(1);
                    if (lat_cnt == '0) begin
                        state <= READ;
                    end
                end

                READ: begin
                    if (beat_cnt != '0) begin
                        addr_cnt <= addr_cnt + mem_addr_t'(1);
                        beat_cnt <= beat_cnt - burst_t'(1);
                    end else begin
                        // Tail cycle with dout_ready already low
                        state <= IDLE;
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign idle       = (state == IDLE);
    assign wr_en      = (state == WRITE);
    assign dout_ready = (state == READ) && (beat_cnt != '0);
    assign beat_addr  = addr_cnt;

    // First read beat appears a fixed time after decode issued start
    property p_read_latency;
        @(posedge clk) disable iff (rst)
        $rose(dout_ready) |-> $past(start, READ_LATENCY);
    endproperty

    a_read_latency: assert property (p_read_latency)
        else $error("dout_ready rose without a start READ_LATENCY cycles before");

endmodule

/* verilog/ddr_cmd_decode.sv */
// Request capture for the burst model. Assumes rd and we are never high together and burstcnt is never zero
`timescale 1ns/10ps

module ddr_cmd_decode (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rd,
    input  logic                      we,
    input  ddr_model_pkg::addr_t      addr,
    input  ddr_model_pkg::burst_t     burstcnt,
    input  logic                      idle,
    output logic                      busy,
    output logic                      start,
    output ddr_model_pkg::op_t        op,
    output ddr_model_pkg::mem_addr_t  start_addr,
    output ddr_model_pkg::burst_t     length
);

    import ddr_model_pkg::*;

    init_t init_cnt;
    logic  init_busy;
    logic  accept;

    // Start-up period, counts down once reset is released
    always_ff @(posedge clk) begin
        if (rst) begin
            init_cnt <= init_t'(INIT_CYCLES);
        end else if (init_cnt != '0) begin
            init_cnt <= init_cnt - init_t'(1);
        end
    end

    assign init_busy = (init_cnt != '0);

    // Start covers the cycle before execute leaves idle
    assign busy   = init_busy | start | ~idle;
    assign accept = (rd | we) & ~busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            start <= 1'b0;
        end else begin
            start <= accept;
        end
    end

    // Request payload, held until the next accepted request
    always_ff @(posedge clk) begin
        if (accept) begin
            op         <= we ? OP_WRITE : OP_READ;
            // Upper address bits fall outside the modelled slice
            start_addr <= addr[MEM_AW-1:0];
            length     <= burstcnt;
        end
    end

    // Client must not ask for both directions at once
    property p_rd_we_exclusive;
        @(posedge clk) disable iff (rst)
        !(rd && we);
    endproperty

    a_rd_we_exclusive: assert property (p_rd_we_exclusive)
        else $error("rd and we high in the same cycle");

    // Zero-length bursts would stall execute on a wrapped counter
    property p_burst_nonzero;
        @(posedge clk) disable iff (rst)
        ((rd || we) && !busy) |-> (burstcnt != '0);
    endproperty

    a_burst_nonzero: assert property (p_burst_nonzero)
        else $error("request accepted with a burst count of zero");

endmodule

/* verilog/ddr_model_pkg.sv */
// Widths and timing of the burst memory model. Only MEM_AW address bits are modelled and READ_LATENCY must be at least 2
package ddr_model_pkg;

    // Client bus widths
    localparam int ADDR_W  = 29;
    localparam int BEAT_W  = 64;
    localparam int BE_W    = 8;
    localparam int BURST_W = 8;

    // Modelled slice of the address space, in beats
    localparam int MEM_AW    = 10;
    localparam int MEM_DEPTH = 2 ** MEM_AW;

    // Cycles from the accepting edge to the first dout_ready
    localparam int READ_LATENCY = 16;
    // Busy period after reset release
    localparam int INIT_CYCLES  = 32;

    // Counter widths derived from the timing above
    localparam int LAT_W  = $clog2(READ_LATENCY);
    localparam int INIT_W = $clog2(INIT_CYCLES + 1);

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [BEAT_W-1:0]  beat_t;
    typedef logic [BE_W-1:0]    be_t;
    typedef logic [BURST_W-1:0] burst_t;
    typedef logic [MEM_AW-1:0]  mem_addr_t;
    typedef logic [LAT_W-1:0]   lat_t;
    typedef logic [INIT_W-1:0]  init_t;

    // Kind of an accepted request
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_t;

endpackage
